/* hw/mips_pkg.sv */
package mips_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int SHAMT_W   = 5;
    localparam int IMM_W     = 16;
    localparam int JTARGET_W = 26;
    localparam int OPCODE_W  = 6;
    localparam int FUNCT_W   = 6;
    localparam int NUM_REGS  = 32;
    localparam int NUM_LANES = 4;
    localparam int LANE_W    = 8;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [SHAMT_W-1:0]   shamt_t;
    typedef logic [IMM_W-1:0]     imm_t;
    typedef logic [JTARGET_W-1:0] jtarget_t;
    typedef logic [OPCODE_W-1:0]  opcode_t;
    typedef logic [FUNCT_W-1:0]   funct_t;

    // lane 0 is the most significant byte of the word (big-endian).
    typedef logic [0:NUM_LANES-1][LANE_W-1:0] byte_lanes_t;

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_JAL   = 6'h03;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_SLTIU = 6'h0b;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_XORI  = 6'h0e;
    localparam opcode_t OP_LUI   = 6'h0f;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    localparam funct_t FN_SLL     = 6'h00;
    localparam funct_t FN_SRL     = 6'h02;
    localparam funct_t FN_SRA     = 6'h03;
    localparam funct_t FN_SLLV    = 6'h04;
    localparam funct_t FN_SRLV    = 6'h06;
    localparam funct_t FN_SRAV    = 6'h07;
    localparam funct_t FN_JR      = 6'h08;
    localparam funct_t FN_SYSCALL = 6'h0c;
    localparam funct_t FN_ADD     = 6'h20;
    localparam funct_t FN_ADDU    = 6'h21;
    localparam funct_t FN_SUB     = 6'h22;
    localparam funct_t FN_SUBU    = 6'h23;
    localparam funct_t FN_AND     = 6'h24;
    localparam funct_t FN_OR      = 6'h25;
    localparam funct_t FN_XOR     = 6'h26;
    localparam funct_t FN_NOR     = 6'h27;
    localparam funct_t FN_SLT     = 6'h2a;
    localparam funct_t FN_SLTU    = 6'h2b;

    localparam reg_idx_t RA_REG = 5'd31;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic    dest_rd;
        logic    link;
        logic    imm_src;
        logic    imm_zero_ext;
        logic    shift_var;
        alu_op_e alu_op;
        logic    reg_write;
        logic    mem_write;
        logic    mem_to_reg;
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
        logic    jump_reg;
        logic    halt_req;
    } ctrl_t;

endpackage

/* hw/mips_pc_unit.sv */
`timescale 1ns/1ps

module mips_pc_unit (
    input  logic               clk,
    input  logic               arst_n,
    input  mips_pkg::ctrl_t    ctrl,
    input  mips_pkg::word_t    rs_data,
    input  mips_pkg::word_t    imm_ext,
    input  mips_pkg::jtarget_t jump_target,
    input  logic               zero,
    output mips_pkg::word_t    pc,
    output mips_pkg::word_t    pc_plus4,
    output logic               commit,
    output logic               mem_write_en,
    output logic               halted
);
    import mips_pkg::*;

    word_t pc_next;
    word_t branch_target;
    logic  branch_taken;

    assign pc_plus4      = pc + word_t'(4);
    assign branch_target = pc_plus4 + {imm_ext[WORD_W-3:0], 2'b00};
    assign branch_taken  = (ctrl.branch_eq & zero) | (ctrl.branch_ne & ~zero);

    // a halted core must not change architectural state.
    assign commit       = ctrl.reg_write & ~halted;
    assign mem_write_en = ctrl.mem_write & ~halted;

    // syscall also holds the PC, so the fetch address stays on it.
    always_comb
    begin
        if (halted || ctrl.halt_req)
            pc_next = pc;
        else if (ctrl.jump_reg)
            pc_next = rs_data;
        else if (ctrl.jump)
            pc_next = {pc_plus4[WORD_W-1:WORD_W-4], jump_target, 2'b00};
        else if (branch_taken)
            pc_next = branch_target;
        else
            pc_next = pc_plus4;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc     <= '0;
            halted <= 1'b0;
        end
        else
        begin
            pc     <= pc_next;
            halted <= halted | ctrl.halt_req;
        end
    end

endmodule

/* hw/mips_decoder.sv */
`timescale 1ns/1ps

module mips_decoder (
    input  mips_pkg::opcode_t opcode,
    input  mips_pkg::funct_t  funct,
    output mips_pkg::ctrl_t   ctrl
);
    import mips_pkg::*;

    always_comb
    begin
        ctrl = '0;
        case (opcode)
            OP_RTYPE:
            begin
                ctrl.dest_rd   = 1'b1;
                ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADD, FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:          ctrl.alu_op = ALU_AND;
                    FN_OR:           ctrl.alu_op = ALU_OR;
                    FN_XOR:          ctrl.alu_op = ALU_XOR;
                    FN_NOR:          ctrl.alu_op = ALU_NOR;
                    FN_SLT:          ctrl.alu_op = ALU_SLT;
                    FN_SLTU:         ctrl.alu_op = ALU_SLTU;
                    FN_SLL:          ctrl.alu_op = ALU_SLL;
                    FN_SRL:          ctrl.alu_op = ALU_SRL;
                    FN_SRA:          ctrl.alu_op = ALU_SRA;
                    FN_SLLV:
                    begin
                        ctrl.alu_op    = ALU_SLL;
                        ctrl.shift_var = 1'b1;
                    end
                    FN_SRLV:
                    begin
                        ctrl.alu_op    = ALU_SRL;
                        ctrl.shift_var = 1'b1;
                    end
                    FN_SRAV:
                    begin
                        ctrl.alu_op    = ALU_SRA;
                        ctrl.shift_var = 1'b1;
                    end
                    FN_JR:
                    begin
                        ctrl.reg_write = 1'b0;
                        ctrl.jump_reg  = 1'b1;
                    end
                    FN_SYSCALL:
                    begin
                        ctrl.reg_write = 1'b0;
                        ctrl.halt_req  = 1'b1;
                    end
                    // unknown function codes fall through as a no-op.
                    default: ctrl = '0;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
            begin
                ctrl.imm_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                case (opcode)
                    OP_SLTI:  ctrl.alu_op = ALU_SLT;
                    OP_SLTIU: ctrl.alu_op = ALU_SLTU;
                    OP_ANDI:  ctrl.alu_op = ALU_AND;
                    OP_ORI:   ctrl.alu_op = ALU_OR;
                    OP_XORI:  ctrl.alu_op = ALU_XOR;
                    OP_LUI:   ctrl.alu_op = ALU_LUI;
                    default:  ctrl.alu_op = ALU_ADD;
                endcase
                ctrl.imm_zero_ext = (opcode == OP_ANDI) || (opcode == OP_ORI) ||
                                    (opcode == OP_XORI);
            end
            OP_LW:
            begin
                ctrl.imm_src    = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            OP_SW:
            begin
                ctrl.imm_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            OP_BEQ:
            begin
                ctrl.alu_op    = ALU_SUB;
                ctrl.branch_eq = 1'b1;
            end
            OP_BNE:
            begin
                ctrl.alu_op    = ALU_SUB;
                ctrl.branch_ne = 1'b1;
            end
            OP_J:    ctrl.jump = 1'b1;
            OP_JAL:
            begin
                ctrl.jump      = 1'b1;
                ctrl.link      = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

/* hw/mips_regfile.sv */
`timescale 1ns/1ps

module mips_regfile (
    input  logic               clk,
    input  logic               arst_n,
    input  mips_pkg::reg_idx_t rs_idx,
    input  mips_pkg::reg_idx_t rt_idx,
    input  mips_pkg::reg_idx_t wr_idx,
    input  mips_pkg::word_t    wr_data,
    input  logic               wr_en,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data
);
    import mips_pkg::*;

    word_t regs [NUM_REGS];

    // register 0 is never written, so it holds the zero it got at reset.
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en && (wr_idx != '0))
        begin
            regs[wr_idx] <= wr_data;
        end
    end

    // reads are combinational and see a write only after the edge.
    assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
    assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

endmodule

/* hw/mips_alu.sv */
`timescale 1ns/1ps

module mips_alu (
    input  mips_pkg::ctrl_t  ctrl,
    input  mips_pkg::word_t  rs_data,
    input  mips_pkg::word_t  rt_data,
    input  mips_pkg::imm_t   imm,
    input  mips_pkg::shamt_t shamt,
    output mips_pkg::word_t  alu_result,
    output mips_pkg::word_t  imm_ext,
    output logic             zero
);
    import mips_pkg::*;

    word_t  op_b;
    word_t  diff;
    shamt_t shift_amt;

    assign imm_ext = ctrl.imm_zero_ext ? {{(WORD_W-IMM_W){1'b0}}, imm}
                                       : {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};

    assign op_b      = ctrl.imm_src ? imm_ext : rt_data;
    assign shift_amt = ctrl.shift_var ? rs_data[SHAMT_W-1:0] : shamt;

    // the branch test always compares the two registers.
    assign diff = rs_data - rt_data;
    assign zero = (diff == '0);

    always_comb
    begin
        case (ctrl.alu_op)
            ALU_ADD:  alu_result = rs_data + op_b;
            ALU_SUB:  alu_result = rs_data - op_b;
            ALU_AND:  alu_result = rs_data & op_b;
            ALU_OR:   alu_result = rs_data | op_b;
            ALU_XOR:  alu_result = rs_data ^ op_b;
            ALU_NOR:  alu_result = ~(rs_data | op_b);
            ALU_SLT:  alu_result = word_t'($signed(rs_data) < $signed(op_b));
            ALU_SLTU: alu_result = word_t'(rs_data < op_b);
            // shifts always act on rt, whatever operand two would be.
            ALU_SLL:  alu_result = rt_data << shift_amt;
            ALU_SRL:  alu_result = rt_data >> shift_amt;
            ALU_SRA:  alu_result = word_t'($signed(rt_data) >>> shift_amt);
            ALU_LUI:  alu_result = {imm, {(WORD_W-IMM_W){1'b0}}};
            default:  alu_result = '0;
        endcase
    end

endmodule

/* hw/mips_mem_writeback.sv */
`timescale 1ns/1ps

module mips_mem_writeback (
    input  mips_pkg::ctrl_t       ctrl,
    input  mips_pkg::word_t       rt_data,
    input  mips_pkg::word_t       alu_result,
    input  mips_pkg::word_t       pc_plus4,
    input  mips_pkg::byte_lanes_t mem_data_out,
    input  mips_pkg::reg_idx_t    rt_idx,
    input  mips_pkg::reg_idx_t    rd_idx,
    output mips_pkg::byte_lanes_t mem_data_in,
    output mips_pkg::word_t       wb_data,
    output mips_pkg::reg_idx_t    wb_idx
);
    import mips_pkg::*;

    word_t load_word;

    // both directions use the same order, lane 0 on bits 31 to 24.
    always_comb
    begin
        for (int i = 0; i < NUM_LANES; i++)
        begin
            mem_data_in[i]                             = rt_data[WORD_W-1-i*LANE_W -: LANE_W];
            load_word[WORD_W-1-i*LANE_W -: LANE_W]     = mem_data_out[i];
        end
    end

    always_comb
    begin
        if (ctrl.link)
            wb_data = pc_plus4;
        else if (ctrl.mem_to_reg)
            wb_data = load_word;
        else
            wb_data = alu_result;
    end

    always_comb
    begin
        if (ctrl.link)
            wb_idx = RA_REG;
        else if (ctrl.dest_rd)
            wb_idx = rd_idx;
        else
            wb_idx = rt_idx;
    end

endmodule

/* hw/mips_core.sv */
`timescale 1ns/1ps

module mips_core (
    input  logic                  clk,
    input  logic                  arst_n,
    output mips_pkg::word_t       inst_addr,
    input  mips_pkg::word_t       inst,
    output mips_pkg::word_t       mem_addr,
    output mips_pkg::byte_lanes_t mem_data_in,
    input  mips_pkg::byte_lanes_t mem_data_out,
    output logic                  mem_write_en,
    output logic                  halted
);
    import mips_pkg::*;

    ctrl_t    ctrl;
    word_t    rs_data;
    word_t    rt_data;
    word_t    alu_result;
    word_t    imm_ext;
    word_t    pc_plus4;
    word_t    wb_data;
    reg_idx_t wb_idx;
    logic     zero;
    logic     commit;

    mips_pc_unit u_pc_unit (
        .clk          (clk),
        .arst_n       (arst_n),
        .ctrl         (ctrl),
        .rs_data      (rs_data),
        .imm_ext      (imm_ext),
        .jump_target  (inst[25:0]),
        .zero         (zero),
        .pc           (inst_addr),
        .pc_plus4     (pc_plus4),
        .commit       (commit),
        .mem_write_en (mem_write_en),
        .halted       (halted)
    );

    mips_decoder u_decoder (
        .opcode (inst[31:26]),
        .funct  (inst[5:0]),
        .ctrl   (ctrl)
    );

    mips_regfile u_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_idx  (inst[25:21]),
        .rt_idx  (inst[20:16]),
        .wr_idx  (wb_idx),
        .wr_data (wb_data),
        .wr_en   (commit),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    mips_alu u_alu (
        .ctrl       (ctrl),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .imm        (inst[15:0]),
        .shamt      (inst[10:6]),
        .alu_result (alu_result),
        .imm_ext    (imm_ext),
        .zero       (zero)
    );

    mips_mem_writeback u_mem_writeback (
        .ctrl         (ctrl),
        .rt_data      (rt_data),
        .alu_result   (alu_result),
        .pc_plus4     (pc_plus4),
        .mem_data_out (mem_data_out),
        .rt_idx       (inst[20:16]),
        .rd_idx       (inst[15:11]),
        .mem_data_in  (mem_data_in),
        .wb_data      (wb_data),
        .wb_idx       (wb_idx)
    );

    assign mem_addr = alu_result;

endmodule

/* dv/mips_core_properties.sv */
`timescale 1ns/1ps

module mips_core_properties (
    input logic            clk,
    input logic            arst_n,
    input mips_pkg::word_t inst_addr,
    input logic            mem_write_en,
    input logic            halted
);

    // the testbench reads this count when the run ends.
    int failures = 0;

    // once the core halts it stays halted until reset.
    halt_sticky: assert property (@(posedge clk) disable iff (!arst_n) halted |=> halted)
    else
    begin
        $error("halted fell while reset was inactive");
        failures++;
    end

    no_store_when_halted: assert property (@(posedge clk) disable iff (!arst_n)
                                           halted |-> !mem_write_en)
    else
    begin
        $error("mem_write_en is high while the core is halted");
        failures++;
    end

    inst_addr_aligned: assert property (@(posedge clk) disable iff (!arst_n)
                                        inst_addr[1:0] == 2'b00)
    else
    begin
        $error("inst_addr is not word aligned");
        failures++;
    end

endmodule

bind mips_core mips_core_properties u_properties (
    .clk          (clk),
    .arst_n       (arst_n),
    .inst_addr    (inst_addr),
    .mem_write_en (mem_write_en),
    .halted       (halted)
);

/* dv/mips_core_tb.sv */
`timescale 1ns/1ps

module mips_core_tb;
    import mips_pkg::*;

    localparam int PAT_WORDS   = 256;
    localparam int MEM_WORDS   = 256;
    localparam int RESET_CYC   = 8;
    localparam int HOLD_CYCLES = 10;

    // syscall is an R-type word with only the function field set.
    localparam word_t SYSCALL_WORD = {OP_RTYPE, 20'h0, FN_SYSCALL};

    logic        clk;
    logic        arst_n;
    word_t       inst_addr;
    word_t       inst;
    word_t       mem_addr;
    byte_lanes_t mem_data_in;
    byte_lanes_t mem_data_out;
    logic        mem_write_en;
    logic        halted;

    word_t pat  [PAT_WORDS];
    word_t imem [MEM_WORDS];
    word_t dmem [MEM_WORDS];

    int n_prog;
    int n_stores;
    int n_final;
    int store_base;
    int final_base;
    int store_idx;
    int cycle_count;
    int cycle_limit;
    int checks;
    int errors;

    mips_core dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst_addr    (inst_addr),
        .inst         (inst),
        .mem_addr     (mem_addr),
        .mem_data_in  (mem_data_in),
        .mem_data_out (mem_data_out),
        .mem_write_en (mem_write_en),
        .halted       (halted)
    );

    always #20 clk = ~clk;

    // both memories are word wide and answer in the same cycle.
    assign inst         = imem[inst_addr[9:2]];
    assign mem_data_out = byte_lanes_t'(dmem[mem_addr[9:2]]);

    always @(posedge clk)
    begin
        if (mem_write_en === 1'b1)
            dmem[mem_addr[9:2]] <= word_t'(mem_data_in);
    end

    // the core parks its fetch address on the first syscall of the program.
    function automatic word_t find_halt_addr();
        for (int i = 0; i < n_prog; i++)
        begin
            if (imem[i] == SYSCALL_WORD)
                return word_t'(4 * i);
        end
        return '1;
    endfunction

    task automatic compare_store();
        word_t exp_addr;
        word_t exp_data;
        if (store_idx >= n_stores)
        begin
            errors++;
            $display("Unexpected store at %0t: address %h follows the last expected store",
                     $time, mem_addr);
        end
        else
        begin
            exp_addr = pat[store_base + 2 * store_idx];
            exp_data = pat[store_base + 2 * store_idx + 1];
            checks += 2;
            if (mem_addr !== exp_addr)
            begin
                errors++;
                $display("Mismatch at %0t: mem_addr expected %h, got %h",
                         $time, exp_addr, mem_addr);
            end
            if (word_t'(mem_data_in) !== exp_data)
            begin
                errors++;
                $display("Mismatch at %0t: mem_data_in expected %h, got %h",
                         $time, exp_data, mem_data_in);
            end
        end
        store_idx++;
    endtask

    // combinational outputs are settled by the falling edge.
    always @(negedge clk)
    begin
        if (arst_n === 1'b1 && mem_write_en === 1'b1)
            compare_store();
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout at %0t: the core never halted within %0d cycles",
                     $time, cycle_limit);
            $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                     checks, errors, dut.u_properties.failures);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial
    begin
        word_t halt_pc;
        word_t exp_addr;
        word_t exp_data;
        clk         = 1'b0;
        arst_n      = 1'b0;
        store_idx   = 0;
        cycle_count = 0;
        checks      = 0;
        errors      = 0;
        void'($urandom(42224));

        $readmemh("dv/mips_patterns.hex", pat);
        n_prog      = pat[0];
        n_stores    = pat[1];
        n_final     = pat[2];
        store_base  = 3 + n_prog;
        final_base  = store_base + 2 * n_stores;
        cycle_limit = 4 * n_prog + 100;

        // words past the program decode as sll $0,$0,0.
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            imem[i] = (i < n_prog) ? pat[3 + i] : '0;
            dmem[i] = $urandom();
        end
        halt_pc = find_halt_addr();

        repeat (RESET_CYC) @(posedge clk);
        arst_n <= 1'b1;

        @(negedge clk);
        checks += 2;
        if (inst_addr !== '0)
        begin
            errors++;
            $display("Mismatch at %0t: inst_addr expected %h, got %h",
                     $time, 32'h0, inst_addr);
        end
        if (halted !== 1'b0)
        begin
            errors++;
            $display("Mismatch at %0t: halted expected 0, got %b", $time, halted);
        end

        while (halted !== 1'b1)
            @(negedge clk);

        repeat (HOLD_CYCLES)
        begin
            @(negedge clk);
            checks++;
            if (inst_addr !== halt_pc)
            begin
                errors++;
                $display("Mismatch at %0t: inst_addr expected %h, got %h",
                         $time, halt_pc, inst_addr);
            end
        end

        checks++;
        if (store_idx != n_stores)
        begin
            errors++;
            $display("Wrong number of stores: the core made %0d, the program expects %0d",
                     store_idx, n_stores);
        end

        for (int i = 0; i < n_final; i++)
        begin
            exp_addr = pat[final_base + 2 * i];
            exp_data = pat[final_base + 2 * i + 1];
            checks++;
            if (dmem[exp_addr[9:2]] !== exp_data)
            begin
                errors++;
                $display("Mismatch at %0t: dmem[%h] expected %h, got %h",
                         $time, exp_addr, exp_data, dmem[exp_addr[9:2]]);
            end
        end

        errors += dut.u_properties.failures;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut.u_properties.failures);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

/* dv/mips_patterns.hex */
// words 0 to 2: program word count, store record count, final word count
// then program words, store records as address/data pairs, final words as address/data pairs
00000048 0000001E 00000005
// program, arithmetic and logic results each followed by a store
20010005 AC010100 2002FFFD AC020104 3C031234 AC030108 34635678 AC03010C
00222020 AC040110 00222822 AC050114 00653024 AC060118 00613825 AC07011C
00624026 AC080120 00614827 AC090124 0041502A AC0A0128 0041582B AC0B012C
00036100 AC0C0130 00026843 AC0D0134 00227006 AC0E0138 304FF0F0 AC0F013C
38308001 AC100140 2C31FFFF AC110144 2472FFF8 AC120148 00239807 AC13014C
2854FFFE AC140150 0023A821 AC150154 0023B023 AC160158 0002BA02 AC17015C
// load round trip, then branches, jumps, jal, jr and syscall
0023C004 AC180160 8C19010C 23390001 AC190164 201A00A1 10250001 AC1A0168
10210001 AC0201FC 14210001 AC01016C 14250001 AC0201FC 08000040 AC0201FC
0C000046 AC1F0170 0000000C AC0101F8 AC0101F8 AC0101F8 AC1A0174 03E00008
// expected stores in order
00000100 00000005 00000104 FFFFFFFD 00000108 12340000 0000010C 12345678
00000110 00000002 00000114 00000008 00000118 00000008 0000011C 1234567D
00000120 EDCBA985 00000124 EDCBA982 00000128 00000001 0000012C 00000000
00000130 23456780 00000134 FFFFFFFE 00000138 07FFFFFF 0000013C 0000F0F0
00000140 00008004 00000144 00000001 00000148 12345670 0000014C 0091A2B3
00000150 00000001 00000154 1234567D 00000158 EDCBA98D 0000015C 00FFFFFF
00000160 468ACF00 00000164 12345679 00000168 000000A1 0000016C 00000005
00000174 000000A1 00000170 00000104
// expected final memory words
0000010C 12345678 00000164 12345679 00000168 000000A1
00000170 00000104 00000174 000000A1

/* sim.f */
hw/mips_pkg.sv
hw/mips_pc_unit.sv
hw/mips_decoder.sv
hw/mips_regfile.sv
hw/mips_alu.sv
hw/mips_mem_writeback.sv
hw/mips_core.sv
dv/mips_core_properties.sv
dv/mips_core_tb.sv
